/* verilog/linkPkg.sv */
`default_nettype none

// ---------------------------------------------------------------------------
// Serial link constants
// ---------------------------------------------------------------------------
package linkPkg;

	// One serial character
	localparam int ByteWidth = 8;

	// Clocks per serial bit, fixed at build time
	localparam int BitPeriod = 8;

	// Counter widths for bit phase and bit index
	localparam int PhaseWidth = $clog2(BitPeriod);
	localparam int IndexWidth = $clog2(ByteWidth);

	// Phase of the bit middle, seen from the start bit edge
	localparam logic [PhaseWidth-1:0] MidPhase = PhaseWidth'(BitPeriod / 2 - 1);
	localparam logic [PhaseWidth-1:0] LastPhase = PhaseWidth'(BitPeriod - 1);
	localparam logic [IndexWidth-1:0] LastBit = IndexWidth'(ByteWidth - 1);

	// Byte stream beat, data plus valid flag
	typedef struct packed {
		logic [ByteWidth-1:0] data;
		logic                 valid;
	} serialByteT;

endpackage

`default_nettype wire

/* verilog/harnessPkg.sv */
`default_nettype none

// ---------------------------------------------------------------------------
// Command format and store constants
// ---------------------------------------------------------------------------
package harnessPkg;

	// Field widths of one host command
	localparam int OpWidth = 8;
	localparam int AddrWidth = 32;
	localparam int DataWidth = 32;
	localparam int CountWidth = 32;

	// Whole command, 13 bytes on the line
	localparam int CmdWidth = OpWidth + AddrWidth + DataWidth + CountWidth;

	// One reply word per command
	localparam int RespWidth = 32;

	// On-chip store
	localparam int MemDepth = 256;
	localparam int MemAddrWidth = 8;

	// Reply for an unknown opcode
	localparam logic [RespWidth-1:0] ErrorWord = '1;

	// Host opcodes
	// Gaps in the encoding are illegal
	typedef enum logic [OpWidth-1:0] {
		OpWrite = 8'd0,
		OpRead  = 8'd2,
		OpFill  = 8'd4
	} opcodeT;

	// Command word
	// op sits in the top byte, so it is the first byte sent
	// Fill uses data as the start value and count as the length
	typedef struct packed {
		opcodeT                op;
		logic [AddrWidth-1:0]  addr;
		logic [DataWidth-1:0]  data;
		logic [CountWidth-1:0] count;
	} commandT;

	// Reply word
	// Echoed data, read data, fill count or ErrorWord
	typedef struct packed {
		logic [RespWidth-1:0] word;
	} respT;

endpackage

`default_nettype wire

/* verilog/uartLink.sv */
`timescale 1ns/1ps
`default_nettype none

module uartLink
	import linkPkg::*;
(
	input  logic       sys_clk_p,
	input  logic       rstN,
	input  logic       rxd,
	output logic       txd,
	output serialByteT rxByte,
	input  logic       rxReady,
	input  serialByteT txByte,
	output logic       txReady
);

	typedef enum logic [1:0] {Idle, Start, Data, Stop} uartStateT;

	// ---------------------------------------------------------------------------
	// Receiver
	// ---------------------------------------------------------------------------

	uartStateT             rxState;
	logic [1:0]            rxSync;
	logic                  rxLine;
	logic [PhaseWidth-1:0] rxPhase;
	logic [IndexWidth-1:0] rxBit;
	logic [ByteWidth-1:0]  rxShift;
	logic [ByteWidth-1:0]  rxData;
	logic                  rxValid;
	logic                  rxSample;
	logic                  rxDone;
	logic                  rxLoad;

	// Line after the two sync flops
	assign rxLine = rxSync[1];

	// Middle of a data bit
	assign rxSample = (rxState == Data) && (rxPhase == LastPhase);

	// Middle of a good stop bit
	assign rxDone = (rxState == Stop) && (rxPhase == LastPhase) && rxLine;

	// A held byte blocks the next one, which is lost
	assign rxLoad = rxDone && (!rxValid || rxReady);

	assign rxByte = '{data: rxData, valid: rxValid};

	always_ff @(posedge sys_clk_p) begin
		if (!rstN) begin
			rxSync <= 2'b11;
			rxState <= Idle;
			rxPhase <= '0;
			rxBit <= '0;
			rxValid <= 1'b0;
		end else begin
			rxSync <= {rxSync[0], rxd};
			case (rxState)
				Idle: begin
					rxPhase <= '0;
					if (!rxLine) begin
						rxState <= Start;
					end
				end
				Start: begin
					// Recheck at mid start bit to reject glitches
					if (rxPhase == MidPhase) begin
						rxPhase <= '0;
						rxBit <= '0;
						rxState <= rxLine ? Idle : Data;
					end else begin
						rxPhase <= rxPhase + 1'b1;
					end
				end
				Data: begin
					if (rxPhase == LastPhase) begin
						rxPhase <= '0;
						rxBit <= rxBit + 1'b1;
						if (rxBit == LastBit) begin
							rxState <= Stop;
						end
					end else begin
						rxPhase <= rxPhase + 1'b1;
					end
				end
				Stop: begin
					// Framing errors just drop the byte
					if (rxPhase == LastPhase) begin
						rxPhase <= '0;
						rxState <= Idle;
					end else begin
						rxPhase <= rxPhase + 1'b1;
					end
				end
				default: rxState <= Idle;
			endcase
			if (rxLoad) begin
				rxValid <= 1'b1;
			end else if (rxReady) begin
				rxValid <= 1'b0;
			end
		end
	end

	// LSB arrives first, so shift in from the top
	always_ff @(posedge sys_clk_p) begin
		if (rxSample) begin
			rxShift <= {rxLine, rxShift[ByteWidth-1:1]};
		end
		if (rxLoad) begin
			rxData <= rxShift;
		end
	end

	// ---------------------------------------------------------------------------
	// Transmitter
	// ---------------------------------------------------------------------------

	uartStateT             txState;
	logic [PhaseWidth-1:0] txPhase;
	logic [IndexWidth-1:0] txBit;
	logic [ByteWidth-1:0]  txShift;
	logic                  txFire;
	logic                  txStep;

	// Busy for start, data and stop bits
	assign txReady = (txState == Idle);
	assign txFire = txByte.valid && txReady;
	assign txStep = (txState == Data) && (txPhase == LastPhase);

	always_ff @(posedge sys_clk_p) begin
		if (!rstN) begin
			txState <= Idle;
			txd <= 1'b1;
			txPhase <= '0;
			txBit <= '0;
		end else begin
			case (txState)
				Idle: begin
					txPhase <= '0;
					if (txFire) begin
						// Start bit from the next cycle on
						txd <= 1'b0;
						txState <= Start;
					end
				end
				Start: begin
					if (txPhase == LastPhase) begin
						txPhase <= '0;
						txBit <= '0;
						txd <= txShift[0];
						txState <= Data;
					end else begin
						txPhase <= txPhase + 1'b1;
					end
				end
				Data: begin
					if (txPhase == LastPhase) begin
						txPhase <= '0;
						if (txBit == LastBit) begin
							txd <= 1'b1;
							txState <= Stop;
						end else begin
							// Bit 1 becomes bit 0 on this same edge
							txd <= txShift[1];
							txBit <= txBit + 1'b1;
						end
					end else begin
						txPhase <= txPhase + 1'b1;
					end
				end
				Stop: begin
					if (txPhase == LastPhase) begin
						txPhase <= '0;
						txState <= Idle;
					end else begin
						txPhase <= txPhase + 1'b1;
					end
				end
				default: txState <= Idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk_p) begin
		if (txFire) begin
			txShift <= txByte.data;
		end else if (txStep) begin
			txShift <= {1'b1, txShift[ByteWidth-1:1]};
		end
	end

	// Upstream shifter must hold its byte while the line is busy
	assert property (@(posedge sys_clk_p) disable iff (!rstN)
		txByte.valid && !txReady |=> txByte.valid && $stable(txByte.data))
		else $error("uartLink: txByte changed while waiting");

endmodule

`default_nettype wire

/* verilog/widthShifter.sv */
`timescale 1ns/1ps
`default_nettype none

module widthShifter #(
	parameter int InWidth = 8,
	parameter int OutWidth = 32
) (
	input  logic                sys_clk_p,
	input  logic                rstN,
	input  logic [InWidth-1:0]  inData,
	input  logic                inValid,
	output logic                inReady,
	output logic [OutWidth-1:0] outData,
	output logic                outValid,
	input  logic                outReady
);

	// Derived from the two port widths
	localparam int WordWidth = (InWidth > OutWidth) ? InWidth : OutWidth;
	localparam int BeatWidth = (InWidth > OutWidth) ? OutWidth : InWidth;
	localparam int Ratio = WordWidth / BeatWidth;
	localparam int CntWidth = $clog2(Ratio);

	logic [WordWidth-1:0] word;
	logic [CntWidth-1:0]  beatCnt;
	logic                 held;
	logic                 inFire;
	logic                 outFire;
	logic                 lastBeat;

	// held marks a full word, owned by the output side
	assign inReady = !held;
	assign outValid = held;
	assign inFire = inValid && inReady;
	assign outFire = outValid && outReady;
	assign lastBeat = (beatCnt == CntWidth'(Ratio - 1));

	generate
		if (InWidth < OutWidth) begin : gPack
			// ---------------------------------------------------------------------
			// Narrow to wide, first beat ends up on top
			// ---------------------------------------------------------------------
			assign outData = word;

			always_ff @(posedge sys_clk_p) begin
				if (!rstN) begin
					held <= 1'b0;
					beatCnt <= '0;
				end else if (inFire) begin
					if (lastBeat) begin
						beatCnt <= '0;
						held <= 1'b1;
					end else begin
						beatCnt <= beatCnt + 1'b1;
					end
				end else if (outFire) begin
					held <= 1'b0;
				end
			end

			always_ff @(posedge sys_clk_p) begin
				if (inFire) begin
					word <= {word[WordWidth-InWidth-1:0], inData};
				end
			end
		end else begin : gUnpack
			// ---------------------------------------------------------------------
			// Wide to narrow, top beat goes out first
			// ---------------------------------------------------------------------
			assign outData = word[WordWidth-1 -: OutWidth];

			always_ff @(posedge sys_clk_p) begin
				if (!rstN) begin
					held <= 1'b0;
					beatCnt <= '0;
				end else if (inFire) begin
					held <= 1'b1;
					beatCnt <= '0;
				end else if (outFire) begin
					if (lastBeat) begin
						held <= 1'b0;
						beatCnt <= '0;
					end else begin
						beatCnt <= beatCnt + 1'b1;
					end
				end
			end

			always_ff @(posedge sys_clk_p) begin
				if (inFire) begin
					word <= inData;
				end else if (outFire) begin
					word <= {word[WordWidth-OutWidth-1:0], {OutWidth{1'b0}}};
				end
			end
		end
	endgenerate

	// Beat counter stays inside one word
	assert property (@(posedge sys_clk_p) disable iff (!rstN)
		int'(beatCnt) < Ratio)
		else $error("widthShifter: beat count out of range");

endmodule

`default_nettype wire

/* verilog/cmdEngine.sv */
`timescale 1ns/1ps
`default_nettype none

module cmdEngine
	import harnessPkg::*;
(
	input  logic                 sys_clk_p,
	input  logic                 rstN,
	input  commandT              cmd,
	input  logic                 cmdValid,
	output logic                 cmdReady,
	output logic [RespWidth-1:0] resp,
	output logic                 respValid,
	input  logic                 respReady
);

	typedef enum logic [1:0] {Idle, Exec, Fill, Respond} engineStateT;

	engineStateT             state;
	logic                    started;
	commandT                 cmdReg;
	respT                    respReg;
	logic [RespWidth-1:0]    mem [MemDepth];
	logic [MemDepth-1:0]     written;
	logic [MemAddrWidth-1:0] fillAddr;
	logic [DataWidth-1:0]    fillValue;
	logic [CountWidth-1:0]   remaining;
	logic [MemAddrWidth-1:0] cmdAddr;
	logic [RespWidth-1:0]    rdWord;
	logic                    cmdFire;
	logic                    memWe;
	logic [MemAddrWidth-1:0] memAddr;
	logic [DataWidth-1:0]    memWdata;

	// ---------------------------------------------------------------------------
	// Handshakes
	// ---------------------------------------------------------------------------

	// Ready one cycle after reset, then only when idle
	assign cmdReady = started && (state == Idle);
	assign cmdFire = cmdValid && cmdReady;
	assign respValid = (state == Respond);
	assign resp = respReg.word;

	// Addresses wrap to the store size
	assign cmdAddr = cmdReg.addr[MemAddrWidth-1:0];

	// Never written words read as zero
	assign rdWord = written[cmdAddr] ? mem[cmdAddr] : '0;

	// Single write port
	// Write uses it in Exec, Fill once per loop cycle
	assign memWe = ((state == Exec) && (cmdReg.op == OpWrite)) || (state == Fill);
	assign memAddr = (state == Fill) ? fillAddr : cmdAddr;
	assign memWdata = (state == Fill) ? fillValue : cmdReg.data;

	// ---------------------------------------------------------------------------
	// Control FSM
	// ---------------------------------------------------------------------------

	always_ff @(posedge sys_clk_p) begin
		if (!rstN) begin
			state <= Idle;
			started <= 1'b0;
			written <= '0;
			remaining <= '0;
		end else begin
			started <= 1'b1;
			case (state)
				Idle: begin
					if (cmdFire) begin
						state <= Exec;
					end
				end
				Exec: begin
					// Zero length fill goes straight to the reply
					if ((cmdReg.op == OpFill) && (cmdReg.count != '0)) begin
						remaining <= cmdReg.count;
						state <= Fill;
					end else begin
						state <= Respond;
					end
				end
				Fill: begin
					remaining <= remaining - 1'b1;
					if (remaining == CountWidth'(1)) begin
						state <= Respond;
					end
				end
				Respond: begin
					if (respReady) begin
						state <= Idle;
					end
				end
				default: state <= Idle;
			endcase
			if (memWe) begin
				written[memAddr] <= 1'b1;
			end
		end
	end

	// ---------------------------------------------------------------------------
	// Datapath
	// ---------------------------------------------------------------------------

	always_ff @(posedge sys_clk_p) begin
		if (memWe) begin
			mem[memAddr] <= memWdata;
		end
	end

	always_ff @(posedge sys_clk_p) begin
		if (cmdFire) begin
			cmdReg <= cmd;
		end
		if (state == Exec) begin
			// Fill loop starts at addr with value data
			fillAddr <= cmdAddr;
			fillValue <= cmdReg.data;
			case (cmdReg.op)
				OpWrite: respReg.word <= cmdReg.data;
				OpRead: respReg.word <= rdWord;
				OpFill: respReg.word <= cmdReg.count;
				default: respReg.word <= ErrorWord;
			endcase
		end else if (state == Fill) begin
			fillAddr <= fillAddr + 1'b1;
			fillValue <= fillValue + 1'b1;
		end
	end

	// No reply while fill writes are still pending
	assert property (@(posedge sys_clk_p) disable iff (!rstN)
		respValid |-> (remaining == '0))
		else $error("cmdEngine: reply raised during fill");

	// Fill loop always makes progress
	assert property (@(posedge sys_clk_p) disable iff (!rstN)
		(state == Fill) |=> remaining < $past(remaining))
		else $error("cmdEngine: fill count did not drop");

endmodule

`default_nettype wire

/* verilog/harnessTop.sv */
`timescale 1ns/1ps
`default_nettype none

module harnessTop
	import linkPkg::*;
	import harnessPkg::*;
(
	input  logic sys_clk_p,
	input  logic rstN,
	input  logic rxd,
	output logic txd
);

	// Byte side of the serial link
	serialByteT           rxByte;
	logic                 rxReady;
	serialByteT           txByte;
	logic [ByteWidth-1:0] txData;
	logic                 txValid;
	logic                 txReady;

	// Word side of the engine
	commandT              cmd;
	logic                 cmdValid;
	logic                 cmdReady;
	logic [RespWidth-1:0] resp;
	logic                 respValid;
	logic                 respReady;

	assign txByte = '{data: txData, valid: txValid};

	uartLink link (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.rxd(rxd),
		.txd(txd),
		.rxByte(rxByte),
		.rxReady(rxReady),
		.txByte(txByte),
		.txReady(txReady)
	);

	// ---------------------------------------------------------------------------
	// 13 bytes in, one command out
	// ---------------------------------------------------------------------------
	widthShifter #(
		.InWidth(ByteWidth),
		.OutWidth(CmdWidth)
	) inShift (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.inData(rxByte.data),
		.inValid(rxByte.valid),
		.inReady(rxReady),
		.outData(cmd),
		.outValid(cmdValid),
		.outReady(cmdReady)
	);

	cmdEngine engine (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.cmd(cmd),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.resp(resp),
		.respValid(respValid),
		.respReady(respReady)
	);

	// ---------------------------------------------------------------------------
	// One reply word out as 4 bytes, MSB first
	// ---------------------------------------------------------------------------
	widthShifter #(
		.InWidth(RespWidth),
		.OutWidth(ByteWidth)
	) outShift (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.inData(resp),
		.inValid(respValid),
		.inReady(respReady),
		.outData(txData),
		.outValid(txValid),
		.outReady(txReady)
	);

endmodule

`default_nettype wire

/* verif/harnessTb.sv */
`timescale 1ns/1ps
`default_nettype none

module harnessTb
	import linkPkg::*;
	import harnessPkg::*;
();

	logic                 sys_clk_p;
	logic                 rstN;
	logic                 rxd;
	logic                 txd;

	// High while no command is in flight
	logic                 lineQuiet;
	int                   errorCount;
	int                   checkCount;

	// Reference copy of the store
	logic [RespWidth-1:0] refMem [MemDepth];

	harnessTop dut (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.rxd(rxd),
		.txd(txd)
	);

	// 4 ns clock
	initial begin
		sys_clk_p = 1'b0;
		forever #2 sys_clk_p = ~sys_clk_p;
	end

	// Reply line rests high whenever the harness has nothing to say
	assert property (@(posedge sys_clk_p) disable iff (!rstN) lineQuiet |-> txd) else begin
		errorCount++;
		$display("[FAIL] %0t txd expected 1 got 0", $time);
	end

	// ------------------------------------------------------------------------
	// Host side serial model
	// ------------------------------------------------------------------------

	// One bit period on rxd, returns 1 ns after a rising edge
	task automatic driveBit(input logic level);
		rxd = level;
		repeat (BitPeriod) @(posedge sys_clk_p);
		#1;
	endtask

	// Start bit, LSB first data, stop bit
	task automatic sendByte(input logic [ByteWidth-1:0] value);
		int i;
		driveBit(1'b0);
		for (i = 0; i < ByteWidth; i++) begin
			driveBit(value[i]);
		end
		driveBit(1'b1);
	endtask

	// Whole command, top byte (the opcode) first
	task automatic sendCommand(input commandT c);
		logic [CmdWidth-1:0] bits;
		int k;
		bits = c;
		@(posedge sys_clk_p);
		#1;
		for (k = CmdWidth / ByteWidth - 1; k >= 0; k--) begin
			sendByte(bits[k*ByteWidth +: ByteWidth]);
		end
	endtask

	// Four reply bytes from txd, sampled on falling edges
	task automatic receiveWord(output logic [RespWidth-1:0] word, output logic gotOk);
		int b;
		int i;
		int waited;
		logic [ByteWidth-1:0] value;
		word = '0;
		gotOk = 1'b1;
		for (b = 0; b < RespWidth / ByteWidth; b++) begin
			waited = 0;
			@(negedge sys_clk_p);
			// Hunt for the start bit, 2000 cycles at most
			while (txd !== 1'b0 && waited < 2000) begin
				@(negedge sys_clk_p);
				waited++;
			end
			if (txd !== 1'b0) begin
				errorCount++;
				$display("No start bit on txd within 2000 cycles, reply lost at %0t", $time);
				gotOk = 1'b0;
				return;
			end
			// Middle of data bit 0 is one and a half bits away
			repeat (BitPeriod + BitPeriod / 2) @(negedge sys_clk_p);
			for (i = 0; i < ByteWidth; i++) begin
				value[i] = txd;
				repeat (BitPeriod) @(negedge sys_clk_p);
			end
			// Now in the middle of the stop bit
			if (txd !== 1'b1) begin
				errorCount++;
				$display("Stop bit on txd was low at %0t", $time);
			end
			word = {word[RespWidth-ByteWidth-1:0], value};
		end
	endtask

	// Send and listen at once, the reply may start before the last stop bit ends
	task automatic exchangeCommand(input commandT c, output logic [RespWidth-1:0] got,
		output logic gotOk);
		lineQuiet = 1'b0;
		fork
			sendCommand(c);
			receiveWord(got, gotOk);
		join
		lineQuiet = 1'b1;
	endtask

	// ------------------------------------------------------------------------
	// Reference model and checking
	// ------------------------------------------------------------------------

	// Expected reply per command rule, updates the reference store
	task automatic predictReply(input commandT c, output logic [RespWidth-1:0] expected);
		logic [MemAddrWidth-1:0] idx;
		logic [CountWidth-1:0] i;
		idx = c.addr[MemAddrWidth-1:0];
		case (c.op)
			OpWrite: begin
				refMem[idx] = c.data;
				expected = c.data;
			end
			OpRead: begin
				expected = refMem[idx];
			end
			OpFill: begin
				// Word i gets data + i, addresses wrap inside the store
				for (i = '0; i < c.count; i++) begin
					refMem[idx + i[MemAddrWidth-1:0]] = c.data + i;
				end
				expected = c.count;
			end
			default: begin
				expected = ErrorWord;
			end
		endcase
	endtask

	task automatic checkReply(input logic [RespWidth-1:0] expected,
		input logic [RespWidth-1:0] got);
		checkCount++;
		assert (got === expected) else begin
			errorCount++;
			$display("[FAIL] %0t resp expected %h got %h", $time, expected, got);
		end
	endtask

	task automatic runCommand(input opcodeT op, input logic [AddrWidth-1:0] addr,
		input logic [DataWidth-1:0] data, input logic [CountWidth-1:0] count);
		commandT c;
		logic [RespWidth-1:0] expected;
		logic [RespWidth-1:0] got;
		logic gotOk;
		c.op = op;
		c.addr = addr;
		c.data = data;
		c.count = count;
		predictReply(c, expected);
		exchangeCommand(c, got, gotOk);
		if (gotOk) begin
			checkReply(expected, got);
		end
	endtask

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------

	initial begin
		logic [AddrWidth-1:0] addr;
		logic [AddrWidth-1:0] base;
		logic [DataWidth-1:0] data;
		logic [CountWidth-1:0] count;
		int n;
		void'($urandom(32'hf7a6c2ed));
		rstN = 1'b0;
		rxd = 1'b1;
		lineQuiet = 1'b0;
		errorCount = 0;
		checkCount = 0;
		for (n = 0; n < MemDepth; n++) begin
			refMem[n] = '0;
		end
		repeat (4) @(posedge sys_clk_p);
		#1;
		rstN = 1'b1;

		// Quiet line after reset
		lineQuiet = 1'b1;
		repeat (200) @(posedge sys_clk_p);
		#1;

		// Write echoes, read returns the same word
		data = $urandom;
		runCommand(OpWrite, 32'h10, data, '0);
		runCommand(OpRead, 32'h10, '0, '0);

		// Fill of 1 to 16 words, with a marker just past the end
		base = 32'h40;
		count = ($urandom % 16) + 1;
		runCommand(OpWrite, base + count, $urandom, '0);
		data = $urandom;
		runCommand(OpFill, base, data, count);
		for (n = 0; n <= int'(count); n++) begin
			runCommand(OpRead, base + 32'(n), '0, '0);
		end

		// One store length above reads back below
		data = $urandom;
		runCommand(OpWrite, 32'(32'h25 + MemDepth), data, '0);
		runCommand(OpRead, 32'h25, '0, '0);

		// Unknown opcode 7, target word must survive
		data = $urandom;
		runCommand(OpWrite, 32'h30, data, '0);
		runCommand(opcodeT'(8'h07), 32'h30, ~data, 32'd3);
		runCommand(OpRead, 32'h30, '0, '0);

		// Random traffic on 8 words, upper address bits random to exercise the wrap
		for (n = 0; n < 20; n++) begin
			addr = ($urandom << 8) | (32'h80 + ($urandom % 8));
			data = $urandom;
			if ($urandom % 2 == 0) begin
				runCommand(OpWrite, addr, data, '0);
			end else begin
				runCommand(OpRead, addr, '0, '0);
			end
		end

		repeat (20) @(posedge sys_clk_p);
		$display("Replies checked %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
verilog/linkPkg.sv
verilog/harnessPkg.sv
verilog/uartLink.sv
verilog/widthShifter.sv
verilog/cmdEngine.sv
verilog/harnessTop.sv
verif/harnessTb.sv

/* run.sh */
#!/bin/sh
# Build the harness testbench with Verilator, run it, then scan the log

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module harnessTb \
	-o harnessSim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/harnessSim > sim.log 2>&1 || true
cat sim.log

grep -q "Errors found" sim.log && { echo "Simulation failed"; exit 1; } || true
grep -q "No errors" sim.log || { echo "Simulation did not finish"; exit 1; }
exit 0
